// ==== rtl/fixed_pkg.sv ====
package fixed_pkg;

  // FFT bin with signed real part in the upper half and imaginary part in the lower half
  localparam int fft_w = 32;

  localparam int power_w  = 32;  // Unsigned bin power
  localparam int energy_w = 32;  // Unsigned filter energy after the /256 scaling
  localparam int acc_w    = 40;  // Mel accumulator

  // Unsigned Q8.8 log value
  localparam int log_w = 16;

  localparam int coef_w    = 16;  // Signed cepstral coefficient
  localparam int cos_frac  = 14;  // Fraction bits of the cosine table
  localparam int dct_acc_w = 36;  // Sum of eight 33-bit products

endpackage

// ==== rtl/mfcc_pkg.sv ====
package mfcc_pkg;

  localparam int n_bins      = 32;
  localparam int num_filters = 8;
  localparam int num_coeffs  = 6;  // Coefficients 1 to 6, C0 is not produced

  // Operating modes. Code 3 behaves as mute
  localparam logic [1:0] mode_features = 2'd0;
  localparam logic [1:0] mode_mute     = 2'd1;
  localparam logic [1:0] mode_log_mel  = 2'd2;

  // Filter on whose rising slope each bin lies
  // Index 8 is the slope above the top centre, only filter 7 takes a share there
  localparam logic [3:0] bin_filter [0:n_bins-1] = '{
    4'd0, 4'd0, 4'd1, 4'd1, 4'd2, 4'd2, 4'd3, 4'd3, 4'd3, 4'd4, 4'd4, 4'd4,
    4'd5, 4'd5, 4'd5, 4'd5, 4'd6, 4'd6, 4'd6, 4'd6, 4'd6, 4'd7, 4'd7, 4'd7,
    4'd7, 4'd7, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8
  };

  // Rising share in 1/256 steps, the lower filter gets 256 minus this
  localparam logic [7:0] bin_weight [0:n_bins-1] = '{
    8'd0,   8'd128, 8'd0,   8'd128, 8'd0,   8'd128, 8'd0,   8'd85,
    8'd170, 8'd0,   8'd85,  8'd170, 8'd0,   8'd64,  8'd128, 8'd192,
    8'd0,   8'd51,  8'd102, 8'd153, 8'd204, 8'd0,   8'd51,  8'd102,
    8'd153, 8'd204, 8'd0,   8'd42,  8'd85,  8'd128, 8'd170, 8'd213
  };

  // Q1.14 cos(pi * k * (n + 0.5) / 8), row k-1 and column n
  localparam logic signed [15:0] dct_cos [0:num_coeffs-1][0:num_filters-1] = '{
    '{ 16'sd16069,  16'sd13623,  16'sd9102,   16'sd3196,
      -16'sd3196,  -16'sd9102,  -16'sd13623, -16'sd16069},
    '{ 16'sd15137,  16'sd6270,  -16'sd6270,  -16'sd15137,
      -16'sd15137, -16'sd6270,   16'sd6270,   16'sd15137},
    '{ 16'sd13623, -16'sd3196,  -16'sd16069, -16'sd9102,
       16'sd9102,   16'sd16069,  16'sd3196,  -16'sd13623},
    '{ 16'sd11585, -16'sd11585, -16'sd11585,  16'sd11585,
       16'sd11585, -16'sd11585, -16'sd11585,  16'sd11585},
    '{ 16'sd9102,  -16'sd16069,  16'sd3196,   16'sd13623,
      -16'sd13623, -16'sd3196,   16'sd16069, -16'sd9102},
    '{ 16'sd6270,  -16'sd15137,  16'sd15137, -16'sd6270,
      -16'sd6270,   16'sd15137, -16'sd15137,  16'sd6270}
  };

endpackage

// ==== rtl/power_spectrum.sv ====
`timescale 1ns/1ps

module power_spectrum (
  input  logic                          clk_in,
  input  logic                          reset,
  input  logic [fixed_pkg::fft_w-1:0]   fft_data,
  input  logic                          fft_valid,
  input  logic                          fft_last,
  output logic                          fft_ready,
  input  logic                          power_ready,
  output logic                          power_valid,
  output logic [fixed_pkg::power_w-1:0] power_data,
  output logic                          power_last
);

  logic signed [fixed_pkg::fft_w/2-1:0] re_part;
  logic signed [fixed_pkg::fft_w/2-1:0] im_part;
  logic [fixed_pkg::power_w-1:0] re_sq;
  logic [fixed_pkg::power_w-1:0] im_sq;

  assign re_part = fft_data[fixed_pkg::fft_w-1 -: fixed_pkg::fft_w/2];
  assign im_part = fft_data[fixed_pkg::fft_w/2-1:0];

  // Each square is at most 2^30, so the sum fits in 32 unsigned bits
  assign re_sq = re_part * re_part;
  assign im_sq = im_part * im_part;

  assign fft_ready = !power_valid || power_ready;  // Empty or draining this cycle

  always_ff @(posedge clk_in) begin
    if (reset) begin
      power_valid <= 1'b0;
    end else if (fft_ready) begin
      power_valid <= fft_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (fft_valid && fft_ready) begin
      power_data <= re_sq + im_sq;
      power_last <= fft_last;
    end
  end

  // A stalled beat keeps its value until mel_filterbank takes it
  power_hold : assert property (@(posedge clk_in) disable iff (reset)
    power_valid && !power_ready |=> $stable(power_data) && $stable(power_last));

endmodule

// ==== rtl/mel_filterbank.sv ====
`timescale 1ns/1ps

module mel_filterbank (
  input  logic                          clk_in,
  input  logic                          reset,
  input  logic [fixed_pkg::power_w-1:0] power_data,
  input  logic                          power_valid,
  input  logic                          power_last,
  output logic                          power_ready,
  input  logic                          filtered_ready,
  output logic                          filtered_valid,
  output logic [mfcc_pkg::num_filters-1:0][fixed_pkg::energy_w-1:0] filtered_data
);

  logic [$clog2(mfcc_pkg::n_bins)-1:0] bin_cnt;
  logic [3:0] cur_filter;
  logic [7:0] w_rise;
  logic [8:0] w_fall;
  logic [fixed_pkg::acc_w-1:0] part_rise;
  logic [fixed_pkg::acc_w-1:0] part_fall;
  logic [fixed_pkg::acc_w-1:0] acc      [mfcc_pkg::num_filters];
  logic [fixed_pkg::acc_w-1:0] share    [mfcc_pkg::num_filters];
  logic [fixed_pkg::acc_w:0]   acc_sum  [mfcc_pkg::num_filters];
  logic [fixed_pkg::acc_w-1:0] acc_next [mfcc_pkg::num_filters];
  logic take_bin;

  assign power_ready = !filtered_valid;  // Stalls while the energies wait
  assign take_bin    = power_valid && power_ready;

  assign cur_filter = mfcc_pkg::bin_filter[bin_cnt];
  assign w_rise     = mfcc_pkg::bin_weight[bin_cnt];
  assign w_fall     = 9'd256 - {1'b0, w_rise};
  assign part_rise  = power_data * w_rise;
  assign part_fall  = power_data * w_fall;

  // Each bin feeds its own filter and the falling slope of the one below
  for (genvar i = 0; i < mfcc_pkg::num_filters; i++) begin : g_filter
    assign share[i] = (cur_filter == 4'(i))     ? part_rise :
                      (cur_filter == 4'(i + 1)) ? part_fall : '0;
    assign acc_sum[i]  = {1'b0, acc[i]} + {1'b0, share[i]};
    assign acc_next[i] = acc_sum[i][fixed_pkg::acc_w] ? '1 :
                         acc_sum[i][fixed_pkg::acc_w-1:0];  // Saturate on a full-scale frame
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      bin_cnt        <= '0;
      filtered_valid <= 1'b0;
      for (int i = 0; i < mfcc_pkg::num_filters; i++) begin
        acc[i] <= '0;
      end
    end else begin
      if (filtered_valid && filtered_ready) begin
        filtered_valid <= 1'b0;
      end
      if (take_bin) begin
        bin_cnt <= power_last ? '0 : bin_cnt + 1'b1;
        for (int i = 0; i < mfcc_pkg::num_filters; i++) begin
          acc[i] <= power_last ? '0 : acc_next[i];
        end
        if (power_last) begin
          filtered_valid <= 1'b1;
        end
      end
    end
  end

  // Energy is the final sum divided by 256
  always_ff @(posedge clk_in) begin
    if (take_bin && power_last) begin
      for (int i = 0; i < mfcc_pkg::num_filters; i++) begin
        filtered_data[i] <= acc_next[i][fixed_pkg::acc_w-1 -: fixed_pkg::energy_w];
      end
    end
  end

  // Frames from the FFT side are exactly 32 bins long
  frame_len : assert property (@(posedge clk_in) disable iff (reset)
    take_bin |-> (power_last == (bin_cnt == $bits(bin_cnt)'(mfcc_pkg::n_bins - 1))));

endmodule

// ==== rtl/log2_approx.sv ====
`timescale 1ns/1ps

module log2_approx (
  input  logic                           clk_in,
  input  logic                           reset,
  input  logic [fixed_pkg::energy_w-1:0] filtered_data,
  input  logic                           filtered_valid,
  output logic                           filtered_ready,
  input  logic                           log_ready,
  output logic                           log_valid,
  output logic [fixed_pkg::log_w-1:0]    log_data
);

  logic [$clog2(fixed_pkg::energy_w)-1:0] lead;
  logic [fixed_pkg::energy_w-1:0] norm;

  // Position of the leading one
  always_comb begin
    lead = '0;
    for (int b = 1; b < fixed_pkg::energy_w; b++) begin
      if (filtered_data[b]) begin
        lead = b[$bits(lead)-1:0];
      end
    end
  end

  // Leading one moved to the MSB, the bits below it form the fraction
  // Zero input gives norm of zero and so a log of zero
  assign norm = filtered_data << (fixed_pkg::energy_w - 1 - lead);

  assign filtered_ready = !log_valid || log_ready;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      log_valid <= 1'b0;
    end else if (filtered_ready) begin
      log_valid <= filtered_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (filtered_valid && filtered_ready) begin
      log_data <= {{(fixed_pkg::log_w/2 - $bits(lead)){1'b0}}, lead,
                   norm[fixed_pkg::energy_w-2 -: fixed_pkg::log_w/2]};
    end
  end

endmodule

// ==== rtl/dct_engine.sv ====
`timescale 1ns/1ps

module dct_engine (
  input  logic                                                    clk_in,
  input  logic                                                    reset,
  input  logic [mfcc_pkg::num_filters-1:0][fixed_pkg::log_w-1:0] log_data,
  input  logic                                                    log_valid,
  output logic                                                    log_ready,
  input  logic                                                    dct_ready,
  output logic                                                    dct_valid,
  output logic signed [fixed_pkg::coef_w-1:0]                     dct_data,
  output logic                                                    dct_last
);

  logic [mfcc_pkg::num_filters-1:0][fixed_pkg::log_w-1:0] log_buf;
  logic busy;
  logic [2:0] coef_k;  // Coefficient being formed, 1 to 6
  logic [3:0] tap;     // Filter index, 8 is the output step
  logic [2:0] row_sel;
  logic [2:0] tap_sel;
  logic signed [15:0] cos_sel;
  logic signed [fixed_pkg::log_w:0] log_sel;
  logic signed [fixed_pkg::log_w+16:0] prod;
  logic signed [fixed_pkg::dct_acc_w-1:0] acc;
  logic signed [fixed_pkg::dct_acc_w-1:0] scaled;
  logic [fixed_pkg::dct_acc_w-fixed_pkg::coef_w:0] upper;
  logic signed [fixed_pkg::coef_w-1:0] coef_sat;

  // While a result waits, the first tap of the next row is prepared
  assign row_sel = (dct_valid && coef_k != 3'(mfcc_pkg::num_coeffs)) ? coef_k : coef_k - 3'd1;
  assign tap_sel = dct_valid ? 3'd0 : tap[2:0];
  assign cos_sel = mfcc_pkg::dct_cos[row_sel][tap_sel];
  assign log_sel = $signed({1'b0, log_buf[tap_sel]});
  assign prod    = log_sel * cos_sel;

  assign scaled = acc >>> fixed_pkg::cos_frac;
  assign upper  = scaled[fixed_pkg::dct_acc_w-1:fixed_pkg::coef_w-1];
  always_comb begin
    if (&upper || !(|upper)) begin
      coef_sat = scaled[fixed_pkg::coef_w-1:0];
    end else if (scaled[fixed_pkg::dct_acc_w-1]) begin
      coef_sat = {1'b1, {(fixed_pkg::coef_w-1){1'b0}}};
    end else begin
      coef_sat = {1'b0, {(fixed_pkg::coef_w-1){1'b1}}};
    end
  end

  assign log_ready = !busy;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      busy      <= 1'b0;
      dct_valid <= 1'b0;
      dct_last  <= 1'b0;
      coef_k    <= 3'd1;
      tap       <= '0;
      acc       <= '0;
    end else if (!busy) begin
      if (log_valid) begin
        busy   <= 1'b1;
        coef_k <= 3'd1;
        tap    <= '0;
        acc    <= '0;
      end
    end else if (!dct_valid) begin
      if (tap == 4'd8) begin
        dct_valid <= 1'b1;
        dct_last  <= (coef_k == 3'(mfcc_pkg::num_coeffs));
      end else begin
        acc <= acc + prod;
        tap <= tap + 4'd1;
      end
    end else if (dct_ready) begin
      dct_valid <= 1'b0;
      dct_last  <= 1'b0;
      if (dct_last) begin
        busy <= 1'b0;
      end else begin
        coef_k <= coef_k + 3'd1;
        acc    <= prod;  // Tap 0 of the next row
        tap    <= 4'd1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (log_valid && log_ready) log_buf <= log_data;
    if (busy && !dct_valid && tap == 4'd8) dct_data <= coef_sat;
  end

  coef_range : assert property (@(posedge clk_in) disable iff (reset)
    coef_k >= 3'd1 && coef_k <= 3'(mfcc_pkg::num_coeffs));

endmodule

// ==== rtl/feature_extractor.sv ====
`timescale 1ns/1ps

module feature_extractor (
  input  logic                           clk_in,
  input  logic                           reset,
  input  logic [1:0]                     mode,
  input  logic [fixed_pkg::fft_w-1:0]    fft_data,
  input  logic                           fft_valid,
  input  logic                           fft_last,
  output logic                           fft_ready,
  input  logic                           feature_ready,
  output logic                           feature_valid,
  output logic [fixed_pkg::coef_w-1:0]   feature_data,
  output logic                           feature_last
);

  logic power_ready, power_valid, power_last;
  logic [fixed_pkg::power_w-1:0] power_data;
  logic filtered_ready, filtered_valid;
  logic [mfcc_pkg::num_filters-1:0][fixed_pkg::energy_w-1:0] filtered_data;
  logic [mfcc_pkg::num_filters-1:0] unit_ready, unit_valid;
  logic [mfcc_pkg::num_filters-1:0][fixed_pkg::log_w-1:0] log_data;
  logic log_valid, log_ready, log_take;
  logic dct_log_valid, dct_log_ready;
  logic dct_ready, dct_valid, dct_last;
  logic signed [fixed_pkg::coef_w-1:0] dct_data;
  logic [1:0] mode_q;  // Mode of the frame now leaving
  logic [mfcc_pkg::num_filters-1:0][fixed_pkg::log_w-1:0] mel_buf;
  logic ser_busy;
  logic [2:0] ser_idx;

  power_spectrum power_spectrum_inst (
    .clk_in, .reset, .fft_data, .fft_valid, .fft_last, .fft_ready,
    .power_ready, .power_valid, .power_data, .power_last
  );

  mel_filterbank mel_filterbank_inst (
    .clk_in, .reset, .power_data, .power_valid, .power_last, .power_ready,
    .filtered_ready, .filtered_valid, .filtered_data
  );

  for (genvar i = 0; i < mfcc_pkg::num_filters; i++) begin : g_log
    log2_approx log2_approx_inst (
      .clk_in, .reset,
      .filtered_data(filtered_data[i]), .filtered_valid, .filtered_ready(unit_ready[i]),
      .log_ready, .log_valid(unit_valid[i]), .log_data(log_data[i])
    );
  end
  assign filtered_ready = unit_ready[0];
  assign log_valid      = unit_valid[0];

  dct_engine dct_engine_inst (
    .clk_in, .reset, .log_data, .log_valid(dct_log_valid), .log_ready(dct_log_ready),
    .dct_ready, .dct_valid, .dct_data, .dct_last
  );

  // A new vector waits until both output paths are idle
  assign log_ready     = dct_log_ready && !ser_busy;
  assign log_take      = log_valid && log_ready;
  assign dct_log_valid = log_valid && !ser_busy && (mode == mfcc_pkg::mode_features);

  always_ff @(posedge clk_in) begin
    if (reset) begin
      mode_q   <= mfcc_pkg::mode_mute;
      ser_busy <= 1'b0;
      ser_idx  <= '0;
    end else if (log_take) begin
      mode_q   <= mode;
      ser_busy <= (mode == mfcc_pkg::mode_log_mel);
      ser_idx  <= '0;
    end else if (ser_busy && feature_ready) begin
      ser_idx <= ser_idx + 3'd1;
      if (ser_idx == 3'(mfcc_pkg::num_filters - 1)) ser_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (log_take) mel_buf <= log_data;
  end

  always_comb begin
    feature_valid = 1'b0;
    feature_data  = '0;
    feature_last  = 1'b0;
    dct_ready     = 1'b0;
    case (mode_q)
      mfcc_pkg::mode_features: begin
        feature_valid = dct_valid;
        feature_data  = dct_data;
        feature_last  = dct_last;
        dct_ready     = feature_ready;
      end
      mfcc_pkg::mode_log_mel: begin
        feature_valid = ser_busy;
        feature_data  = mel_buf[ser_idx];
        feature_last  = (ser_idx == 3'(mfcc_pkg::num_filters - 1));
      end
      default: ;  // Mute drops the frame
    endcase
  end

  // The eight log units share one handshake and must never drift apart
  log_lockstep : assert property (@(posedge clk_in) disable iff (reset)
    unit_valid == {mfcc_pkg::num_filters{unit_valid[0]}} &&
    unit_ready == {mfcc_pkg::num_filters{unit_ready[0]}});

endmodule

// ==== tests/feature_extractor_tb.sv ====
`timescale 1ns/1ps

module feature_extractor_tb;

  localparam int clk_period    = 4;
  localparam int num_frames    = 11;
  localparam int settle_cycles = 6;  // Last bin to log vector accept takes three edges
  localparam int n_bins        = mfcc_pkg::n_bins;
  localparam longint acc_max   = (longint'(1) << fixed_pkg::acc_w) - 1;

  // Mode of each frame, code 3 should act as mute
  localparam logic [1:0] frame_mode [num_frames] = '{
    mfcc_pkg::mode_log_mel, mfcc_pkg::mode_log_mel, mfcc_pkg::mode_log_mel,
    mfcc_pkg::mode_features, mfcc_pkg::mode_features, mfcc_pkg::mode_features,
    mfcc_pkg::mode_features, mfcc_pkg::mode_mute, mfcc_pkg::mode_log_mel,
    2'd3, mfcc_pkg::mode_features
  };
  localparam logic [num_frames-1:0] zero_frames = 11'b000_0100_0000;  // Frame 6 is silent

  logic clk_in;
  logic reset;
  logic [1:0] mode;
  logic [fixed_pkg::fft_w-1:0] fft_data;
  logic fft_valid;
  logic fft_last;
  logic fft_ready;
  logic feature_ready;
  logic feature_valid;
  logic [fixed_pkg::coef_w-1:0] feature_data;
  logic feature_last;

  logic [31:0] lfsr_state = 32'd72271;
  logic [31:0] ready_state = 32'd72271;  // Back-pressure pattern
  logic [fixed_pkg::fft_w-1:0] frame_bins [n_bins];
  logic [fixed_pkg::coef_w:0] exp_q [$];  // {last, data} in output order
  logic head_present;
  logic [fixed_pkg::coef_w:0] head_beat;
  logic was_stalled;
  logic [fixed_pkg::coef_w-1:0] held_data;
  logic held_last;

  feature_extractor DUT (
    .clk_in, .reset, .mode, .fft_data, .fft_valid, .fft_last, .fft_ready,
    .feature_ready, .feature_valid, .feature_data, .feature_last
  );

  always #(clk_period / 2) clk_in = ~clk_in;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic longint clip_acc(input longint v);
    if (v > acc_max) return acc_max;
    return v;
  endfunction

  // Q8.8 log, integer part is the leading one position
  function automatic logic [fixed_pkg::log_w-1:0] leading_one_log(input logic [31:0] e);
    int p;
    logic [31:0] frac;
    if (e == 0) return '0;
    p = 0;
    for (int b = 0; b < 32; b++) begin
      if (e[b]) p = b;
    end
    frac = (p >= 8) ? (e >> (p - 8)) : (e << (8 - p));
    return {3'd0, 5'(p), frac[7:0]};
  endfunction

  task automatic make_frame(input logic silent);
    logic [31:0] draw;
    logic signed [15:0] re_v;
    logic signed [15:0] im_v;
    int sh;
    draw = random_bits(4);
    sh = int'(draw[3:0]);  // Per-frame amplitude spread
    for (int b = 0; b < n_bins; b++) begin
      draw = random_bits(32);
      re_v = draw[31:16];
      im_v = draw[15:0];
      re_v = re_v >>> sh;
      im_v = im_v >>> sh;
      frame_bins[b] = silent ? '0 : {re_v, im_v};
    end
  endtask

  // Reference model of one frame, pushes the beats the frame should produce
  task automatic expect_frame(input logic [1:0] m);
    longint acc [mfcc_pkg::num_filters];
    logic [fixed_pkg::log_w-1:0] logs [mfcc_pkg::num_filters];
    logic signed [15:0] re_v;
    logic signed [15:0] im_v;
    longint pw;
    longint sum;
    int f;
    int w;
    for (int i = 0; i < mfcc_pkg::num_filters; i++) begin
      acc[i] = 0;
    end
    for (int b = 0; b < n_bins; b++) begin
      re_v = frame_bins[b][31:16];
      im_v = frame_bins[b][15:0];
      pw = longint'(re_v) * longint'(re_v) + longint'(im_v) * longint'(im_v);
      f = int'(mfcc_pkg::bin_filter[b]);
      w = int'(mfcc_pkg::bin_weight[b]);
      if (f < mfcc_pkg::num_filters) acc[f] = clip_acc(acc[f] + pw * w);
      if (f > 0) acc[f - 1] = clip_acc(acc[f - 1] + pw * (256 - w));  // Falling slope
    end
    for (int i = 0; i < mfcc_pkg::num_filters; i++) begin
      logs[i] = leading_one_log(32'(acc[i] >> 8));
    end
    if (m == mfcc_pkg::mode_log_mel) begin
      for (int i = 0; i < mfcc_pkg::num_filters; i++) begin
        exp_q.push_back({i == mfcc_pkg::num_filters - 1, logs[i]});
      end
    end else if (m == mfcc_pkg::mode_features) begin
      for (int k = 0; k < mfcc_pkg::num_coeffs; k++) begin
        sum = 0;
        for (int n = 0; n < mfcc_pkg::num_filters; n++) begin
          sum += longint'(logs[n]) * longint'(mfcc_pkg::dct_cos[k][n]);
        end
        sum = sum >>> fixed_pkg::cos_frac;
        if (sum > 32767) sum = 32767;
        else if (sum < -32768) sum = -32768;
        exp_q.push_back({k == mfcc_pkg::num_coeffs - 1, 16'(sum)});
      end
    end
  endtask

  task automatic send_frame();
    for (int b = 0; b < n_bins; b++) begin
      fft_data  <= frame_bins[b];
      fft_valid <= 1'b1;
      fft_last  <= (b == n_bins - 1);
      do @(posedge clk_in); while (!fft_ready);
    end
    fft_valid <= 1'b0;
    fft_last  <= 1'b0;
    fft_data  <= '0;
  endtask

  always @(posedge clk_in) begin : drive_ready
    ready_state = lfsr_next(ready_state);
    feature_ready <= ready_state[0];
  end

  // Head of the queue is registered so checks see the beat due at this edge
  always @(posedge clk_in) begin
    if (!reset && feature_valid && feature_ready && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
    head_present <= (exp_q.size() != 0);
    head_beat    <= (exp_q.size() != 0) ? exp_q[0] : '0;
    was_stalled  <= !reset && feature_valid && !feature_ready;
    held_data    <= feature_data;
    held_last    <= feature_last;
  end

  initial begin
    clk_in    = 1'b0;
    reset     = 1'b1;
    mode      = mfcc_pkg::mode_mute;
    fft_data  = '0;
    fft_valid = 1'b0;
    fft_last  = 1'b0;
    feature_ready = 1'b0;
    repeat (2) @(posedge clk_in);
    reset <= 1'b0;
    @(posedge clk_in);
    assert (!feature_valid && fft_ready) else
      abort_run($sformatf("ERROR feature_valid %h fft_ready %h after reset",
                          feature_valid, fft_ready));
    for (int f = 0; f < num_frames; f++) begin
      mode <= frame_mode[f];
      make_frame(zero_frames[f]);
      expect_frame(frame_mode[f]);
      send_frame();
      repeat (settle_cycles) @(posedge clk_in);
      // Next mode goes in while this frame may still be leaving
      if (f + 1 < num_frames) mode <= frame_mode[f + 1];
      while (exp_q.size() != 0) @(posedge clk_in);
    end
    repeat (settle_cycles) @(posedge clk_in);  // Room for a stray trailing beat to show
    $display("test passed");
    $finish;
  end

  initial begin
    #(num_frames * 400 * clk_period);
    abort_run("watchdog expired before all frames were checked");
  end

  no_extra_beat : assert property (@(posedge clk_in) disable iff (reset)
    feature_valid |-> head_present)
    else abort_run("feature_valid is high while no beat is expected");

  data_match : assert property (@(posedge clk_in) disable iff (reset)
    feature_valid && feature_ready && head_present |-> feature_data == head_beat[15:0])
    else abort_run($sformatf("ERROR feature_data got %h expected %h",
                             $sampled(feature_data), $sampled(head_beat[15:0])));

  last_match : assert property (@(posedge clk_in) disable iff (reset)
    feature_valid && feature_ready && head_present |-> feature_last == head_beat[16])
    else abort_run($sformatf("ERROR feature_last got %h expected %h",
                             $sampled(feature_last), $sampled(head_beat[16])));

  // Stalled beat must stay put
  hold_valid : assert property (@(posedge clk_in) disable iff (reset)
    was_stalled |-> feature_valid)
    else abort_run("feature_valid dropped before the stalled beat was taken");

  hold_data : assert property (@(posedge clk_in) disable iff (reset)
    was_stalled |-> feature_data == held_data)
    else abort_run($sformatf("ERROR feature_data changed under stall from %h to %h",
                             $sampled(held_data), $sampled(feature_data)));

  hold_last : assert property (@(posedge clk_in) disable iff (reset)
    was_stalled |-> feature_last == held_last)
    else abort_run($sformatf("ERROR feature_last changed under stall from %h to %h",
                             $sampled(held_last), $sampled(feature_last)));

endmodule

// ==== src.f ====
rtl/fixed_pkg.sv
rtl/mfcc_pkg.sv
rtl/power_spectrum.sv
rtl/mel_filterbank.sv
rtl/log2_approx.sv
rtl/dct_engine.sv
rtl/feature_extractor.sv
tests/feature_extractor_tb.sv

// ==== Makefile ====
# Verilator build and run for the MFCC feature extractor

VERILATOR  ?= verilator
TOP        ?= feature_extractor_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
